//--- verilog/gmii_pkg.sv
// GMII receive line definitions for 8-bit 1G mode only; MII nibble mode is not covered.
package gmii_pkg;

    // ------------------------------------------------------------------
    // Line types
    // ------------------------------------------------------------------

    // One byte as carried on gmii_rxd.
    typedef logic [7:0] gmii_byte_t;

    // Raw receive inputs sampled together on rx_clk.
    typedef struct packed {
        gmii_byte_t data;
        logic       dv;
        logic       er;
    } gmii_rx_t;

    // ------------------------------------------------------------------
    // Line constants
    // ------------------------------------------------------------------

    // Preamble filler byte.
    localparam gmii_byte_t preamble_byte = 8'h55;

    // Start-frame delimiter, last byte before the destination address.
    localparam gmii_byte_t sfd_byte = 8'hD5;

endpackage

//--- verilog/eth_frame_pkg.sv
// Frame-level definitions; lengths count the FCS, and the CRC residue assumes an uncomplemented register.
package eth_frame_pkg;

    // ------------------------------------------------------------------
    // CRC-32
    // ------------------------------------------------------------------

    typedef logic [31:0] crc_t;

    // Reflected IEEE 802.3 polynomial, shifted LSB first.
    localparam crc_t crc_poly = 32'hEDB88320;

    localparam crc_t crc_init = 32'hFFFFFFFF;

    // Register value after a frame and its own FCS have been shifted in.
    localparam crc_t crc_residue = 32'hDEBB20E3;

    // ------------------------------------------------------------------
    // Frame length
    // ------------------------------------------------------------------

    // Saturating byte count, FCS included.
    typedef logic [15:0] frame_len_t;

    localparam frame_len_t min_frame_len = 16'd64;
    localparam frame_len_t max_frame_len = 16'd1518;

    // ------------------------------------------------------------------
    // Internal and output streams
    // ------------------------------------------------------------------

    // One frame byte out of the framer. err is sticky over the frame so far.
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
        logic       first;
        logic       last;
        logic       err;
    } rx_beat_t;

    // Verdict of one checker, only meaningful with valid.
    typedef struct packed {
        logic valid;
        logic bad;
    } rx_check_t;

    // Output byte stream, bad only on the last byte.
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
        logic       last;
        logic       bad;
    } rx_stream_t;

endpackage

//--- verilog/rx_sfd_framer.sv
// Frames without a leading 0x55 preamble are dropped; cfg_rx_enable is sampled only at the delimiter.
`timescale 1ns/1ps

module rx_sfd_framer (
    input  logic                    rx_clk,
    input  logic                    rx_rst,
    input  gmii_pkg::gmii_rx_t      gmii_in,
    input  logic                    cfg_rx_enable,
    output eth_frame_pkg::rx_beat_t beat
);
    import gmii_pkg::*;
    import eth_frame_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_preamble,
        st_payload,
        st_drop
    } state_t;

    state_t   state_q;
    state_t   state_d;
    gmii_rx_t in_q;
    logic     first_q;
    logic     err_q;
    rx_beat_t beat_d;

    // ------------------------------------------------------------------
    // Input register
    // ------------------------------------------------------------------

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            in_q <= '0;
        end else begin
            in_q <= gmii_in;
        end
    end

    // ------------------------------------------------------------------
    // Framing FSM
    // ------------------------------------------------------------------

    always_comb begin
        state_d = state_q;
        beat_d  = '0;
        case (state_q)
            st_idle: begin
                if (in_q.dv) begin
                    state_d = (in_q.data == preamble_byte) ? st_preamble : st_drop;
                end
            end
            st_preamble: begin
                if (!in_q.dv) begin
                    state_d = st_idle;
                end else if (in_q.data == sfd_byte) begin
                    state_d = cfg_rx_enable ? st_payload : st_drop;
                end else if (in_q.data != preamble_byte) begin
                    state_d = st_drop;
                end
            end
            st_payload: begin
                // The live dv tells whether the registered byte is the last one.
                if (in_q.dv) begin
                    beat_d.valid = 1'b1;
                    beat_d.data  = in_q.data;
                    beat_d.first = first_q;
                    beat_d.last  = !gmii_in.dv;
                    beat_d.err   = err_q | in_q.er;
                end
                if (!in_q.dv || !gmii_in.dv) begin
                    state_d = st_idle;
                end
            end
            st_drop: begin
                if (!in_q.dv) begin
                    state_d = st_idle;
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            state_q <= st_idle;
            first_q <= 1'b0;
            err_q   <= 1'b0;
            beat    <= '0;
        end else begin
            state_q <= state_d;
            beat    <= beat_d;
            // Arm first and clear the sticky error at the delimiter.
            if (state_q != st_payload && state_d == st_payload) begin
                first_q <= 1'b1;
                err_q   <= 1'b0;
            end else if (beat_d.valid) begin
                first_q <= 1'b0;
                err_q   <= beat_d.err;
            end
        end
    end

endmodule

//--- verilog/rx_fcs_check.sv
// Checks the FCS by residue, so the FCS bytes must stay in the beat stream.
`timescale 1ns/1ps

module rx_fcs_check (
    input  logic                     rx_clk,
    input  logic                     rx_rst,
    input  eth_frame_pkg::rx_beat_t  beat,
    output eth_frame_pkg::rx_check_t fcs_chk
);
    import eth_frame_pkg::*;

    crc_t crc_q;
    crc_t crc_seed;
    crc_t crc_next;

    // Shift one byte into a reflected CRC, LSB first.
    function automatic crc_t crc_byte(input crc_t crc, input logic [7:0] data);
        crc_t c;
        c = crc ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ crc_poly) : (c >> 1);
        end
        return c;
    endfunction

    // ------------------------------------------------------------------
    // Running CRC
    // ------------------------------------------------------------------

    always_comb begin
        crc_seed = beat.first ? crc_init : crc_q;
        crc_next = crc_byte(crc_seed, beat.data);
    end

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            crc_q <= crc_init;
        end else if (beat.valid) begin
            crc_q <= crc_next;
        end
    end

    // ------------------------------------------------------------------
    // Verdict on the last byte
    // ------------------------------------------------------------------

    always_comb begin
        fcs_chk.valid = beat.valid & beat.last;
        fcs_chk.bad   = fcs_chk.valid & (crc_next != crc_residue);
    end

endmodule

//--- verilog/rx_length_check.sv
// Length counts every byte after the delimiter including the FCS; the counter saturates at 65535.
`timescale 1ns/1ps

module rx_length_check (
    input  logic                     rx_clk,
    input  logic                     rx_rst,
    input  eth_frame_pkg::rx_beat_t  beat,
    output eth_frame_pkg::rx_check_t len_chk
);
    import eth_frame_pkg::*;

    frame_len_t len_q;
    frame_len_t len_cur;

    // Count including the current beat.
    always_comb begin
        if (beat.first) begin
            len_cur = frame_len_t'(1);
        end else if (len_q == '1) begin
            len_cur = len_q;
        end else begin
            len_cur = len_q + frame_len_t'(1);
        end
    end

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            len_q <= '0;
        end else if (beat.valid) begin
            len_q <= len_cur;
        end
    end

    // Runt or oversized.
    always_comb begin
        len_chk.valid = beat.valid & beat.last;
        len_chk.bad   = len_chk.valid & ((len_cur < min_frame_len) || (len_cur > max_frame_len));
    end

endmodule

//--- verilog/rx_stream_out.sv
// Output stage has no ready input; the consumer must take every valid byte.
`timescale 1ns/1ps

module rx_stream_out (
    input  logic                      rx_clk,
    input  logic                      rx_rst,
    input  eth_frame_pkg::rx_beat_t   beat,
    input  eth_frame_pkg::rx_check_t  fcs_chk,
    input  eth_frame_pkg::rx_check_t  len_chk,
    output eth_frame_pkg::rx_stream_t rx_out,
    output logic                      rx_start_packet,
    output logic                      rx_error_bad_frame,
    output logic                      rx_error_bad_fcs
);
    import eth_frame_pkg::*;

    rx_stream_t out_d;
    logic       frame_err;
    logic       fcs_err;

    // ------------------------------------------------------------------
    // Merge beat and verdicts
    // ------------------------------------------------------------------

    always_comb begin
        // rx_er or a length violation, both counted as framing errors.
        frame_err = beat.err | (len_chk.valid & len_chk.bad);
        fcs_err   = fcs_chk.valid & fcs_chk.bad;

        out_d.valid = beat.valid;
        out_d.data  = beat.data;
        out_d.last  = beat.valid & beat.last;
        out_d.bad   = out_d.last & (frame_err | fcs_err);
    end

    // ------------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------------

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            rx_out             <= '0;
            rx_start_packet    <= 1'b0;
            rx_error_bad_frame <= 1'b0;
            rx_error_bad_fcs   <= 1'b0;
        end else begin
            rx_out             <= out_d;
            rx_start_packet    <= beat.valid & beat.first;
            rx_error_bad_frame <= out_d.last & frame_err;
            rx_error_bad_fcs   <= out_d.last & fcs_err;
        end
    end

endmodule

//--- verilog/eth_mac_rx.sv
// Receive-only 1G MAC on one clock; fixed three-cycle latency from GMII input to rx_out, FCS kept.
`timescale 1ns/1ps

module eth_mac_rx (
    input  logic                      rx_clk,
    input  logic                      rx_rst,
    input  gmii_pkg::gmii_rx_t        gmii_in,
    input  logic                      cfg_rx_enable,
    output eth_frame_pkg::rx_stream_t rx_out,
    output logic                      rx_start_packet,
    output logic                      rx_error_bad_frame,
    output logic                      rx_error_bad_fcs
);
    import eth_frame_pkg::*;

    rx_beat_t  beat;
    rx_check_t fcs_chk;
    rx_check_t len_chk;

    // Preamble, delimiter and byte framing.
    rx_sfd_framer u_framer (
        .rx_clk        (rx_clk),
        .rx_rst        (rx_rst),
        .gmii_in       (gmii_in),
        .cfg_rx_enable (cfg_rx_enable),
        .beat          (beat)
    );

    // ------------------------------------------------------------------
    // Checkers, side by side on the same beat
    // ------------------------------------------------------------------

    rx_fcs_check u_fcs_check (
        .rx_clk  (rx_clk),
        .rx_rst  (rx_rst),
        .beat    (beat),
        .fcs_chk (fcs_chk)
    );

    rx_length_check u_length_check (
        .rx_clk  (rx_clk),
        .rx_rst  (rx_rst),
        .beat    (beat),
        .len_chk (len_chk)
    );

    rx_stream_out u_stream_out (
        .rx_clk             (rx_clk),
        .rx_rst             (rx_rst),
        .beat               (beat),
        .fcs_chk            (fcs_chk),
        .len_chk            (len_chk),
        .rx_out             (rx_out),
        .rx_start_packet    (rx_start_packet),
        .rx_error_bad_frame (rx_error_bad_frame),
        .rx_error_bad_fcs   (rx_error_bad_fcs)
    );

endmodule

//--- test/eth_mac_rx_sva.sv
// Output stream rules of eth_mac_rx; reset is asynchronous but is sampled here on rx_clk.
`timescale 1ns/1ps

module eth_mac_rx_sva (
    input logic                      rx_clk,
    input logic                      rx_rst,
    input eth_frame_pkg::rx_stream_t rx_out,
    input logic                      rx_start_packet,
    input logic                      rx_error_bad_frame,
    input logic                      rx_error_bad_fcs
);

    // ------------------------------------------------------------------
    // Stream rules
    // ------------------------------------------------------------------

    // Nothing leaves the MAC while reset is held.
    quiet_in_reset: assert property (@(posedge rx_clk)
        rx_rst |-> (!rx_out.valid && !rx_start_packet && !rx_error_bad_frame
                    && !rx_error_bad_fcs))
        else $error("output stream active during reset");

    start_with_valid: assert property (@(posedge rx_clk) disable iff (rx_rst)
        rx_start_packet |-> rx_out.valid)
        else $error("start pulse without a valid output byte");

    // Error pulses belong to the final byte.
    errors_on_last: assert property (@(posedge rx_clk) disable iff (rx_rst)
        (rx_error_bad_frame || rx_error_bad_fcs) |-> rx_out.last)
        else $error("error pulse away from the last byte");

    bad_on_last: assert property (@(posedge rx_clk) disable iff (rx_rst)
        rx_out.bad |-> rx_out.last)
        else $error("bad flag away from the last byte");

endmodule

bind eth_mac_rx eth_mac_rx_sva u_sva (
    .rx_clk             (rx_clk),
    .rx_rst             (rx_rst),
    .rx_out             (rx_out),
    .rx_start_packet    (rx_start_packet),
    .rx_error_bad_frame (rx_error_bad_frame),
    .rx_error_bad_fcs   (rx_error_bad_fcs)
);

//--- test/tb_eth_mac_rx.sv
// Sends frames with a 7-byte preamble and a 12-cycle idle gap; output order is checked, exact latency is not.
`timescale 1ns/1ps

module tb_eth_mac_rx;
    import gmii_pkg::*;
    import eth_frame_pkg::*;

    // One expected output byte with the pulses that belong to it.
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       bad;
        logic       start;
        logic       bad_frame;
        logic       bad_fcs;
    } exp_beat_t;

    typedef struct packed {
        logic frame_err;
        logic fcs_err;
    } exp_flags_t;

    logic       rx_clk;
    logic       rx_rst;
    gmii_rx_t   gmii_in;
    logic       cfg_rx_enable;
    rx_stream_t rx_out;
    logic       rx_start_packet;
    logic       rx_error_bad_frame;
    logic       rx_error_bad_fcs;

    logic [7:0] frame_buf[$];
    exp_beat_t  exp_q[$];
    exp_beat_t  exp_cur;
    int         mismatch_count;
    int         other_count;
    int         byte_count;
    int         checked_count;
    logic       timed_out;

    eth_mac_rx uut (
        .rx_clk             (rx_clk),
        .rx_rst             (rx_rst),
        .gmii_in            (gmii_in),
        .cfg_rx_enable      (cfg_rx_enable),
        .rx_out             (rx_out),
        .rx_start_packet    (rx_start_packet),
        .rx_error_bad_frame (rx_error_bad_frame),
        .rx_error_bad_fcs   (rx_error_bad_fcs)
    );

    always #50 rx_clk = ~rx_clk;

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------

    // Bit-serial CRC-32 over frame_buf[0 .. n-1], returned complemented.
    function automatic logic [31:0] crc32_of(input int n);
        logic [31:0] c;
        logic        fb;
        c = 32'hFFFFFFFF;
        for (int k = 0; k < n; k++) begin
            for (int b = 0; b < 8; b++) begin
                fb = c[0] ^ frame_buf[k][b];
                c  = {1'b0, c[31:1]};
                if (fb) begin
                    c = c ^ 32'hEDB88320;
                end
            end
        end
        return ~c;
    endfunction

    // Random payload plus FCS, LSB byte first; flip_idx corrupts one byte afterwards.
    function automatic void build_frame(input int total_len, input int flip_idx);
        logic [31:0] fcs;
        frame_buf.delete();
        for (int k = 0; k < total_len - 4; k++) begin
            frame_buf.push_back(8'($urandom));
        end
        fcs = crc32_of(total_len - 4);
        for (int k = 0; k < 4; k++) begin
            frame_buf.push_back(fcs[8*k +: 8]);
        end
        if (flip_idx >= 0) begin
            frame_buf[flip_idx] = frame_buf[flip_idx] ^ 8'h01;
        end
    endfunction

    function automatic exp_flags_t expected_flags(input logic er_seen);
        exp_flags_t  f;
        logic [31:0] rx_fcs;
        int          n;
        n           = frame_buf.size();
        rx_fcs      = {frame_buf[n-1], frame_buf[n-2], frame_buf[n-3], frame_buf[n-4]};
        f.frame_err = er_seen || (n < 64) || (n > 1518);
        f.fcs_err   = (crc32_of(n - 4) != rx_fcs);
        return f;
    endfunction

    task automatic queue_expected(input logic er_seen);
        exp_flags_t f;
        exp_beat_t  e;
        int         n;
        f = expected_flags(er_seen);
        n = frame_buf.size();
        for (int k = 0; k < n; k++) begin
            e.data      = frame_buf[k];
            e.start     = (k == 0);
            e.last      = (k == n - 1);
            e.bad       = e.last & (f.frame_err | f.fcs_err);
            e.bad_frame = e.last & f.frame_err;
            e.bad_fcs   = e.last & f.fcs_err;
            exp_q.push_back(e);
        end
    endtask

    // ------------------------------------------------------------------
    // GMII driver
    // ------------------------------------------------------------------

    task automatic drive_cycle(input logic [7:0] data, input logic dv, input logic er);
        @(negedge rx_clk);
        gmii_in.data = data;
        gmii_in.dv   = dv;
        gmii_in.er   = er;
    endtask

    // Preamble, delimiter, the bytes of frame_buf and the idle gap.
    task automatic send_frame(input logic bad_preamble, input int er_idx);
        for (int k = 0; k < 7; k++) begin
            drive_cycle((bad_preamble && k == 3) ? 8'h5D : 8'h55, 1'b1, 1'b0);
        end
        drive_cycle(8'hD5, 1'b1, 1'b0);
        for (int k = 0; k < frame_buf.size(); k++) begin
            drive_cycle(frame_buf[k], 1'b1, k == er_idx);
        end
        for (int k = 0; k < 12; k++) begin
            drive_cycle(8'h00, 1'b0, 1'b0);
        end
    endtask

    task automatic finish_run();
        $display("Checked %0d bytes: %0d mismatches, %0d other errors",
                 checked_count, mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    task automatic wait_drained(input int limit);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < limit) begin
            @(negedge rx_clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            other_count++;
            timed_out = 1'b1;
            $display("Timeout at %0t: %0d expected bytes never came out of the DUT",
                     $time, exp_q.size());
        end
    endtask

    // ------------------------------------------------------------------
    // Comparing process
    // ------------------------------------------------------------------

    task automatic check_value(input string what, input logic [7:0] got, input logic [7:0] want);
        assert (got == want) else begin
            mismatch_count++;
            $display("Mismatch at %0t: byte %0d %s got %0h expected %0h",
                     $time, byte_count, what, got, want);
        end
    endtask

    always @(negedge rx_clk) begin
        if (rx_rst === 1'b0) begin
            if (rx_out.valid) begin
                assert (exp_q.size() != 0) else begin
                    other_count++;
                    $display("Error at %0t: the DUT put out a byte while no frame was expected",
                             $time);
                end
                if (exp_q.size() != 0) begin
                    exp_cur = exp_q.pop_front();
                    checked_count++;
                    check_value("data", rx_out.data, exp_cur.data);
                    check_value("last", 8'(rx_out.last), 8'(exp_cur.last));
                    check_value("bad", 8'(rx_out.bad), 8'(exp_cur.bad));
                    check_value("start pulse", 8'(rx_start_packet), 8'(exp_cur.start));
                    check_value("bad frame pulse", 8'(rx_error_bad_frame), 8'(exp_cur.bad_frame));
                    check_value("bad fcs pulse", 8'(rx_error_bad_fcs), 8'(exp_cur.bad_fcs));
                    byte_count = exp_cur.last ? 0 : byte_count + 1;
                end
            end else begin
                assert (!rx_start_packet && !rx_error_bad_frame && !rx_error_bad_fcs) else begin
                    other_count++;
                    $display("Error at %0t: a status pulse came without an output byte", $time);
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------

    // All frame groups; stops early once the DUT falls behind.
    task automatic run_frames();
        // Good frames at both length limits and in between.
        build_frame(64, -1);
        queue_expected(1'b0);
        send_frame(1'b0, -1);
        build_frame(1518, -1);
        queue_expected(1'b0);
        send_frame(1'b0, -1);
        for (int k = 0; k < 2; k++) begin
            build_frame(int'($urandom_range(1518, 64)), -1);
            queue_expected(1'b0);
            send_frame(1'b0, -1);
        end
        wait_drained(50);
        if (timed_out) begin
            return;
        end

        // FCS mismatch, runt, oversize and rx_er.
        build_frame(int'($urandom_range(300, 64)), 10);
        queue_expected(1'b0);
        send_frame(1'b0, -1);
        build_frame(60, -1);
        queue_expected(1'b0);
        send_frame(1'b0, -1);
        build_frame(1519, -1);
        queue_expected(1'b0);
        send_frame(1'b0, -1);
        build_frame(100, -1);
        queue_expected(1'b1);
        send_frame(1'b0, 40);
        wait_drained(50);
        if (timed_out) begin
            return;
        end

        // Dropped frames, each followed by a good one.
        cfg_rx_enable = 1'b0;
        build_frame(80, -1);
        send_frame(1'b0, -1);
        cfg_rx_enable = 1'b1;
        build_frame(90, -1);
        queue_expected(1'b0);
        send_frame(1'b0, -1);
        wait_drained(50);
        if (timed_out) begin
            return;
        end
        build_frame(80, -1);
        send_frame(1'b1, -1);
        build_frame(70, -1);
        queue_expected(1'b0);
        send_frame(1'b0, -1);
        wait_drained(50);
        if (timed_out) begin
            return;
        end

        // Back-to-back frames at the minimum gap.
        for (int k = 0; k < 5; k++) begin
            build_frame(int'($urandom_range(200, 64)), -1);
            queue_expected(1'b0);
            send_frame(1'b0, -1);
        end
        wait_drained(50);
    endtask

    initial begin
        rx_clk         = 1'b0;
        rx_rst         = 1'b1;
        gmii_in        = '0;
        cfg_rx_enable  = 1'b1;
        mismatch_count = 0;
        other_count    = 0;
        byte_count     = 0;
        checked_count  = 0;
        timed_out      = 1'b0;
        void'($urandom(32'hd7db5dd6));
        repeat (2) @(negedge rx_clk);
        rx_rst = 1'b0;

        run_frames();
        finish_run();
    end

endmodule

//--- compile.f
verilog/gmii_pkg.sv
verilog/eth_frame_pkg.sv
verilog/rx_sfd_framer.sv
verilog/rx_fcs_check.sv
verilog/rx_length_check.sv
verilog/rx_stream_out.sv
verilog/eth_mac_rx.sv
test/eth_mac_rx_sva.sv
test/tb_eth_mac_rx.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the eth_mac_rx testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv -f compile.f --top-module tb_eth_mac_rx -o sim_tb
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/sim_tb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1
